// File: vlog.f
+incdir+.
soc_pkg.sv
bus_decode.sv
ram.sv
uart_tx.sv
periph_regs.sv
soc_top.sv
soc_assert.sv
tb_soc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test: failure reported"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test: run did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_soc.sv
`include "soc_consts.svh"

module tb_soc;
    timeunit 1ns;
    timeprecision 100ps;

    import soc_pkg::*;

    localparam int          period       = 40;
    localparam int          ram_loops    = 8;
    localparam int          frame_cycles = 10 * `SOC_UART_DIV;
    localparam int          test_cycles  = 5 + 6 * ram_loops + 12 + 4 * frame_cycles + 16;
    localparam int          margin       = 200;
    localparam logic [31:0] led_addr     = `SOC_PERIPH_BASE + `SOC_LED_OFS;
    localparam logic [31:0] data_addr    = `SOC_PERIPH_BASE + `SOC_UART_DATA_OFS;
    localparam logic [31:0] stat_addr    = `SOC_PERIPH_BASE + `SOC_UART_STAT_OFS;
    localparam logic [31:0] void_addr    = 32'h8000_0000;   // nothing mapped here.

    logic       pll_clk;
    logic       rst;
    bus_req_t   req;
    bus_rsp_t   rsp;
    logic [7:0] leds;
    logic       uart_tx_pin;
    int         seed;
    int         errors;
    int         checks;

    soc_top soc_top_i (
        .pll_clk     (pll_clk),
        .rst         (rst),
        .req         (req),
        .rsp         (rsp),
        .leds        (leds),
        .uart_tx_pin (uart_tx_pin)
    );

    always #(period / 2) pll_clk = ~pll_clk;

    initial begin
        #((test_cycles + margin) * period);
        $display("watchdog expired after %0d ns, tests did not complete",
                 (test_cycles + margin) * period);
        $display("sim failed");
        $finish;
    end

    // ------------------------------
    // checks and bus tasks
    // ------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  mask);
        logic [31:0] lanes;
        lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};   // bytes taken new.
        return (new_word & lanes) | (old_word & ~lanes);
    endfunction

    task automatic put_request(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] wmask);
        @(negedge pll_clk);
        req.addr   = addr;
        req.wdata  = wdata;
        req.wmask  = wmask;
        req.strobe = 1'b1;
    endtask

    task automatic release_bus();
        @(negedge pll_clk);
        req.strobe = 1'b0;
    endtask

    task automatic check_rsp(input string name, input logic [31:0] expected);
        if (rsp.valid !== 1'b1) begin
            checks++;
            errors++;
            $display("%s: no valid response one cycle after the read", name);
        end else begin
            check_value(name, expected, rsp.rdata);
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wmask);
        put_request(addr, wdata, wmask);
        release_bus();
    endtask

    task automatic read_check(input logic [31:0] addr, input logic [31:0] expected,
                              input string name);
        put_request(addr, 32'h0, 4'h0);
        release_bus();
        check_rsp(name, expected);
    endtask

    // ------------------------------
    // uart helpers
    // ------------------------------
    task automatic receive_frame(input string name, input logic [7:0] expected);
        int         waited;
        logic       seen;
        logic       start_bit;
        logic       stop_bit;
        logic [7:0] data;
        waited = 0;
        seen   = 1'b0;
        data   = 8'h00;
        while (!seen && waited < 4 * `SOC_UART_DIV) begin
            @(negedge pll_clk);
            seen = (uart_tx_pin === 1'b0);
            waited++;
        end
        if (!seen) begin
            checks++;
            errors++;
            $display("%s: no start bit on uart_tx_pin within %0d cycles", name, waited);
        end else begin
            repeat (`SOC_UART_DIV / 2 - 1) @(negedge pll_clk);   // middle of start bit.
            start_bit = uart_tx_pin;
            for (int i = 0; i < 8; i++) begin
                repeat (`SOC_UART_DIV) @(negedge pll_clk);
                data[i] = uart_tx_pin;   // lsb first.
            end
            repeat (`SOC_UART_DIV) @(negedge pll_clk);
            stop_bit = uart_tx_pin;
            check_value({name, "_start"}, 32'h0, {31'h0, start_bit});
            check_value(name, {24'h0, expected}, {24'h0, data});
            check_value({name, "_stop"}, 32'h1, {31'h0, stop_bit});
        end
    endtask

    task automatic wait_uart_idle(input string name);
        logic busy;
        int   tries;
        busy  = 1'b1;
        tries = 0;
        while (busy && tries < frame_cycles) begin
            put_request(stat_addr, 32'h0, 4'h0);
            release_bus();
            busy = (rsp.valid !== 1'b1) || rsp.rdata[0];   // no response counts as busy.
            tries++;
        end
        check_value(name, 32'h0, {31'h0, busy});
    endtask

    task automatic watch_line_idle(input int cycles);
        int lows;
        lows = 0;
        repeat (cycles) begin
            @(negedge pll_clk);
            if (uart_tx_pin !== 1'b1) begin
                lows++;
            end
        end
        checks++;
        if (lows != 0) begin
            errors++;
            $display("uart line went low in %0d cycles after the frame ended", lows);
        end
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        logic [31:0] addr;
        logic [31:0] old_word;
        logic [31:0] new_word;
        logic [31:0] ram_word;
        logic [3:0]  mask;
        logic [7:0]  led_byte;
        logic [7:0]  tx_first;
        logic [7:0]  tx_second;
        seed     = 32'h36f35174;
        errors   = 0;
        checks   = 0;
        pll_clk  = 1'b0;
        rst      = 1'b1;
        req      = '0;
        ram_word = 32'h0;
        addr     = 32'h0;
        repeat (5) @(negedge pll_clk);
        rst = 1'b0;

        for (int i = 0; i < ram_loops; i++) begin
            addr     = $random(seed) & 32'h0000_fffc;   // word aligned in ram space.
            old_word = $random(seed);
            new_word = $random(seed);
            mask     = 4'($random(seed));
            if (mask == 4'h0) begin
                mask = 4'h1;   // keep it a write.
            end
            bus_write(addr, old_word, 4'hf);
            bus_write(addr, new_word, mask);
            ram_word = merge_bytes(old_word, new_word, mask);
            read_check(addr, ram_word, "ram_byte_mask");
        end

        led_byte = 8'($random(seed));
        bus_write(led_addr, {24'h0, led_byte}, 4'b0001);
        check_value("led_pins", {24'h0, led_byte}, {24'h0, leds});
        read_check(led_addr, {24'h0, led_byte}, "led_readback");

        tx_first = 8'($random(seed));
        bus_write(data_addr, {24'h0, tx_first}, 4'b0001);
        receive_frame("uart_frame", tx_first);
        wait_uart_idle("uart_frame_idle");

        tx_first  = 8'($random(seed));
        tx_second = ~tx_first;
        bus_write(data_addr, {24'h0, tx_first}, 4'b0001);
        fork
            receive_frame("uart_busy_frame", tx_first);
            begin
                repeat (2 * `SOC_UART_DIV) @(negedge pll_clk);
                bus_write(data_addr, {24'h0, tx_second}, 4'b0001);   // must be lost.
                read_check(stat_addr, 32'h1, "uart_status_busy");
            end
        join
        wait_uart_idle("uart_status_idle");
        watch_line_idle(12 * `SOC_UART_DIV);

        put_request(addr, 32'h0, 4'h0);
        put_request(led_addr, 32'h0, 4'h0);
        check_rsp("b2b_ram", ram_word);
        put_request(void_addr, 32'h0, 4'h0);
        check_rsp("b2b_led", {24'h0, led_byte});
        release_bus();
        check_rsp("b2b_unmapped", 32'h0);
        repeat (2) @(negedge pll_clk);

        $display("checks %0d, errors %0d, assertion errors %0d",
                 checks, errors, soc_top_i.soc_assert_i.fail_count);
        if (errors == 0 && soc_top_i.soc_assert_i.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: soc_assert.sv
`include "soc_consts.svh"

module soc_assert (
    input logic              pll_clk,
    input logic              rst,
    input soc_pkg::bus_req_t req,
    input soc_pkg::bus_rsp_t rsp,
    input logic [7:0]        leds,
    input logic              uart_tx_pin,
    input logic              tx_busy,
    input logic              tx_start
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] led_addr = `SOC_PERIPH_BASE + `SOC_LED_OFS;
    localparam int          div      = `SOC_UART_DIV;

    int unsigned fail_count = 0;   // number of failed assertions.
    logic [7:0]  led_shadow;       // byte of the last led write.
    logic        rd_strobe;

    assign rd_strobe = req.strobe && (req.wmask == 4'b0000);

    always_ff @(posedge pll_clk) begin
        if (rst) begin
            led_shadow <= 8'h00;
        end else if (req.strobe && req.wmask[0] && (req.addr == led_addr)) begin
            led_shadow <= req.wdata[7:0];
        end
    end

    // ------------------------------
    // bus response
    // ------------------------------
    rsp_follows_read: assert property (@(posedge pll_clk) disable iff (rst)
        rsp.valid == $past(rd_strobe))
    else begin
        fail_count++;
        $error("rsp.valid is not one cycle after a read strobe");
    end

    leds_match: assert property (@(posedge pll_clk) disable iff (rst)
        leds == led_shadow)
    else begin
        fail_count++;
        $error("leds %h differ from last led write %h", leds, led_shadow);
    end

    // ------------------------------
    // uart line
    // ------------------------------
    line_idle_high: assert property (@(posedge pll_clk) disable iff (rst)
        !tx_busy |-> uart_tx_pin)
    else begin
        fail_count++;
        $error("uart line low while not busy");
    end

    for (genvar i = 1; i <= div; i++) begin : g_start
        start_low: assert property (@(posedge pll_clk) disable iff (rst)
            $past(tx_start, i) |-> !uart_tx_pin)
        else begin
            fail_count++;
            $error("start bit not low %0d cycles after tx_start", i);
        end
    end

    // stop bit is the tenth bit period of the frame.
    for (genvar i = 9 * div + 1; i <= 10 * div; i++) begin : g_stop
        stop_high: assert property (@(posedge pll_clk) disable iff (rst)
            $past(tx_start, i) |-> uart_tx_pin)
        else begin
            fail_count++;
            $error("stop bit not high %0d cycles after tx_start", i);
        end
    end

endmodule

bind soc_top soc_assert soc_assert_i (
    .pll_clk     (pll_clk),
    .rst         (rst),
    .req         (req),
    .rsp         (rsp),
    .leds        (leds),
    .uart_tx_pin (uart_tx_pin),
    .tx_busy     (periph_regs_i.tx_busy),
    .tx_start    (periph_regs_i.tx_start)
);

// File: soc_top.sv
module soc_top (
    input  logic              pll_clk,
    input  logic              rst,
    input  soc_pkg::bus_req_t req,
    output soc_pkg::bus_rsp_t rsp,
    output logic [7:0]        leds,
    output logic              uart_tx_pin
);
    import soc_pkg::*;

    bus_req_t    ram_req;
    bus_req_t    per_req;
    logic [31:0] ram_rdata;
    logic [31:0] per_rdata;

    // ------------------------------
    // decode
    // ------------------------------
    bus_decode bus_decode_i (
        .pll_clk   (pll_clk),
        .rst       (rst),
        .req       (req),
        .ram_req   (ram_req),
        .per_req   (per_req),
        .ram_rdata (ram_rdata),
        .per_rdata (per_rdata),
        .rsp       (rsp)
    );

    // ------------------------------
    // targets
    // ------------------------------
    ram ram_i (
        .pll_clk (pll_clk),
        .req     (ram_req),
        .rdata   (ram_rdata)
    );

    periph_regs periph_regs_i (
        .pll_clk     (pll_clk),
        .rst         (rst),
        .req         (per_req),
        .rdata       (per_rdata),
        .leds        (leds),
        .uart_tx_pin (uart_tx_pin)
    );

endmodule

// File: periph_regs.sv
`include "soc_consts.svh"

module periph_regs (
    input  logic              pll_clk,
    input  logic              rst,
    input  soc_pkg::bus_req_t req,
    output logic [31:0]       rdata,
    output logic [7:0]        leds,
    output logic              uart_tx_pin
);

    localparam logic [`SOC_PERIPH_AW-1:0] led_ofs       = `SOC_LED_OFS;
    localparam logic [`SOC_PERIPH_AW-1:0] uart_data_ofs = `SOC_UART_DATA_OFS;
    localparam logic [`SOC_PERIPH_AW-1:0] uart_stat_ofs = `SOC_UART_STAT_OFS;

    logic [`SOC_PERIPH_AW-1:0] ofs;
    logic                      wr;
    logic                      rd;
    logic                      uart_wr;
    logic [7:0]                tx_byte;
    logic                      tx_start;
    logic                      tx_busy;

    assign ofs = req.addr[`SOC_PERIPH_AW-1:0];
    assign wr  = req.strobe && (req.wmask != 4'b0000);
    assign rd  = req.strobe && (req.wmask == 4'b0000);

    // byte 0 only, dropped while a frame is going out.
    assign uart_wr = wr && req.wmask[0] && (ofs == uart_data_ofs) && !tx_busy;

    // ------------------------------
    // led and uart launch
    // ------------------------------
    always_ff @(posedge pll_clk) begin
        if (rst) begin
            leds     <= 8'h00;
            tx_start <= 1'b0;
        end else begin
            if (wr && req.wmask[0] && (ofs == led_ofs)) begin
                leds <= req.wdata[7:0];
            end
            tx_start <= uart_wr;   // one cycle pulse.
        end
    end

    always_ff @(posedge pll_clk) begin
        if (uart_wr) begin
            tx_byte <= req.wdata[7:0];
        end
    end

    // ------------------------------
    // read path
    // ------------------------------
    always_ff @(posedge pll_clk) begin
        if (rd) begin
            case (ofs)
                led_ofs:       rdata <= {24'h0, leds};
                uart_stat_ofs: rdata <= {31'h0, tx_busy};
                default:       rdata <= 32'h0;   // uart data is write only.
            endcase
        end
    end

    uart_tx uart_tx_i (
        .pll_clk  (pll_clk),
        .rst      (rst),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .tx       (uart_tx_pin)
    );

endmodule

// File: uart_tx.sv
`include "soc_consts.svh"

module uart_tx (
    input  logic       pll_clk,
    input  logic       rst,
    input  logic [7:0] tx_byte,
    input  logic       tx_start,
    output logic       tx_busy,
    output logic       tx
);
    import soc_pkg::*;

    localparam int               cnt_w    = $clog2(`SOC_UART_DIV + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`SOC_UART_DIV - 1);

    uart_state_e      state;
    logic [cnt_w-1:0] cnt;       // cycles into the current bit.
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;

    // busy already in the cycle of the start pulse.
    assign tx_busy = tx_start || (state != uart_idle);

    // ------------------------------
    // 8n1 frame
    // ------------------------------
    always_ff @(posedge pll_clk) begin
        if (rst) begin
            state   <= uart_idle;
            cnt     <= '0;
            bit_idx <= 3'd0;
            tx      <= 1'b1;   // line idles high.
        end else begin
            case (state)
                uart_idle: begin
                    if (tx_start) begin
                        state <= uart_start;
                        cnt   <= '0;
                        tx    <= 1'b0;   // start bit.
                    end
                end
                uart_start: begin
                    if (cnt == cnt_last) begin
                        state   <= uart_data;
                        cnt     <= '0;
                        bit_idx <= 3'd0;
                        tx      <= shreg[0];   // lsb first.
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                uart_data: begin
                    if (cnt == cnt_last) begin
                        cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= uart_stop;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shreg[1];
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == cnt_last) begin
                        state <= uart_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // shift register, loaded on launch and stepped per data bit.
    always_ff @(posedge pll_clk) begin
        if (state == uart_idle && tx_start) begin
            shreg <= tx_byte;
        end else if (state == uart_data && cnt == cnt_last) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

// File: ram.sv
`include "soc_consts.svh"

module ram (
    input  logic              pll_clk,
    input  soc_pkg::bus_req_t req,
    output logic [31:0]       rdata
);

    localparam int depth = 1 << `SOC_RAM_AW;

    logic [31:0]            mem [0:depth-1];
    logic [`SOC_RAM_AW-1:0] word_addr;
    logic                   rd;

    assign word_addr = req.addr[`SOC_RAM_AW+1:2];   // byte address to word.
    assign rd        = req.wmask == 4'b0000;

    // ------------------------------
    // byte lanes
    // ------------------------------
    // each lane writes only under its own mask bit.
    always_ff @(posedge pll_clk) begin
        if (req.strobe) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wmask[b]) begin
                    mem[word_addr][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // read word is held until the next read.
    always_ff @(posedge pll_clk) begin
        if (req.strobe && rd) begin
            rdata <= mem[word_addr];
        end
    end

endmodule

// File: bus_decode.sv
`include "soc_consts.svh"

module bus_decode (
    input  logic              pll_clk,
    input  logic              rst,
    input  soc_pkg::bus_req_t req,
    output soc_pkg::bus_req_t ram_req,
    output soc_pkg::bus_req_t per_req,
    input  logic [31:0]       ram_rdata,
    input  logic [31:0]       per_rdata,
    output soc_pkg::bus_rsp_t rsp
);
    import soc_pkg::*;

    localparam logic [31:0] periph_base = `SOC_PERIPH_BASE;

    target_e tgt;
    target_e tgt_q;   // target of the request one cycle back.
    logic    rd_q;    // that request was a read.

    // ------------------------------
    // address decode
    // ------------------------------
    always_comb begin
        if (req.addr[31:`SOC_RAM_AW+2] == '0) begin
            tgt = tgt_ram;
        end else if (req.addr[31:`SOC_PERIPH_AW] == periph_base[31:`SOC_PERIPH_AW]) begin
            tgt = tgt_periph;
        end else begin
            tgt = tgt_none;   // unmapped, writes are lost.
        end
    end

    always_comb begin
        ram_req        = req;
        ram_req.strobe = req.strobe && (tgt == tgt_ram);
        per_req        = req;
        per_req.strobe = req.strobe && (tgt == tgt_periph);
    end

    always_ff @(posedge pll_clk) begin
        if (rst) begin
            tgt_q <= tgt_none;
            rd_q  <= 1'b0;
        end else begin
            tgt_q <= tgt;
            rd_q  <= req.strobe && (req.wmask == 4'b0000);
        end
    end

    // ------------------------------
    // response mux
    // ------------------------------
    always_comb begin
        rsp.valid = rd_q;
        case (tgt_q)
            tgt_ram:    rsp.rdata = ram_rdata;
            tgt_periph: rsp.rdata = per_rdata;
            default:    rsp.rdata = 32'h0;   // unmapped reads zero.
        endcase
    end

endmodule

// File: soc_pkg.sv
package soc_pkg;

    // ------------------------------
    // bus request and response
    // ------------------------------
    typedef struct packed {
        logic [31:0] addr;     // byte address.
        logic [31:0] wdata;
        logic [3:0]  wmask;    // all zero is a read.
        logic        strobe;   // one cycle per request.
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        valid;
    } bus_rsp_t;

    // ------------------------------
    // decode and uart states
    // ------------------------------
    typedef enum logic [1:0] {
        tgt_none,
        tgt_ram,
        tgt_periph
    } target_e;

    typedef enum logic [1:0] {
        uart_idle,
        uart_start,
        uart_data,
        uart_stop
    } uart_state_e;

endpackage

// File: soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// ------------------------------
// address map
// ------------------------------

// word address bits of the ram, 16 k words.
`define SOC_RAM_AW 14

`define SOC_PERIPH_BASE 32'h0001_0000

// byte address bits inside the peripheral window.
`define SOC_PERIPH_AW 4

// ------------------------------
// peripheral register offsets
// ------------------------------
`define SOC_LED_OFS 0
`define SOC_UART_DATA_OFS 4
`define SOC_UART_STAT_OFS 8

// pll_clk cycles per uart bit.
`define SOC_UART_DIV 4

`endif
